// ==== bench/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

logic [`XLEN-1:0] arch_regs [32];
logic [`XLEN-1:0] arch_mem [`DRAM_DEPTH];
logic [`XLEN-1:0] arch_pc;
logic             arch_halted;

task automatic reset_model();
    for (int i = 0; i < 32; i++) arch_regs[i] = '0;
    for (int i = 0; i < `DRAM_DEPTH; i++) arch_mem[i] = '0;
    arch_pc     = `RESET_PC;
    arch_halted = 1'b0;
endtask

// executes one word at arch_pc and reports the register write it makes
task automatic step_model(input logic [`INST_WIDTH-1:0] word, output logic wen,
                          output logic [`REG_ADDR_WIDTH-1:0] rd,
                          output logic [`XLEN-1:0] data, output logic bad);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] dword;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;
    logic [2:0]       f3;
    logic [6:0]       f7;
    a       = arch_regs[word[19:15]];
    b       = arch_regs[word[24:20]];
    f3      = word[14:12];
    f7      = word[31:25];
    imm_i   = {{52{word[31]}}, word[31:20]};
    imm_s   = {{52{word[31]}}, word[31:25], word[11:7]};
    imm_b   = {{52{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j   = {{44{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    imm_u   = {{32{word[31]}}, word[31:12], 12'b0};
    rd      = word[11:7];
    wen     = 1'b0;
    data    = '0;
    bad     = 1'b0;
    sum     = a + b;
    next_pc = arch_pc + 64'd4;
    case (opcode_e'(word[6:0]))
        OP: begin
            wen  = (f3 == 3'b000) && (f7 == 7'h00 || f7 == 7'h20);
            data = (f7 == 7'h20) ? a - b : sum;
            bad  = !wen;
        end
        OP_IMM: begin
            wen  = (f3 == 3'b000 || f3 == 3'b011);
            data = (f3 == 3'b011) ? {63'b0, a < imm_i} : a + imm_i;
            bad  = !wen;
        end
        OP_32: begin
            wen  = (f3 == 3'b000 && f7 == 7'h00);
            data = {{32{sum[31]}}, sum[31:0]};
            bad  = !wen;
        end
        LOAD: begin
            addr  = a + imm_i;
            dword = arch_mem[addr[8:3]];
            data  = addr[2] ? {{32{dword[63]}}, dword[63:32]} : {{32{dword[31]}}, dword[31:0]};
            wen   = (f3 == 3'b010);
            bad   = !wen;
        end
        STORE: begin
            addr = a + imm_s;
            bad  = (f3 != 3'b011);
            if (!bad) arch_mem[addr[8:3]] = b;
        end
        BRANCH: begin
            bad = (f3 != 3'b000 && f3 != 3'b001);
            if ((f3 == 3'b000) ? (a == b) : (a != b)) next_pc = arch_pc + imm_b;
        end
        JAL: begin
            wen     = 1'b1;
            data    = arch_pc + 64'd4;
            next_pc = arch_pc + imm_j;
        end
        JALR: begin
            wen     = (f3 == 3'b000);
            data    = arch_pc + 64'd4;
            next_pc = (a + imm_i) & ~64'd1;
            bad     = !wen;
        end
        LUI: begin
            wen  = 1'b1;
            data = imm_u;
        end
        AUIPC: begin
            wen  = 1'b1;
            data = arch_pc + imm_u;
        end
        SYSTEM: begin
            bad         = (word != `EBREAK_INST);
            arch_halted = 1'b1;
        end
        default: bad = 1'b1;
    endcase
    if (bad) begin
        wen         = 1'b0;
        arch_halted = 1'b1;
    end else begin
        if (wen && rd != '0) arch_regs[rd] = data;
        arch_pc = next_pc;
    end
endtask

`endif

// ==== bench/tb_rv_core.sv ====
`include "rv_defs.svh"

module tb_rv_core import rv_isa_pkg::*; ();

    localparam int PROG_LEN = 256;
    localparam int TIMEOUT  = 4 * PROG_LEN + 100;

    logic                       clk;
    logic                       rst_n;
    logic [`INST_WIDTH-1:0]     inst = `EBREAK_INST;
    logic                       inst_valid = 1'b0;
    logic [`XLEN-1:0]           fetch_pc;
    logic                       commit;
    logic [`XLEN-1:0]           commit_pc;
    logic                       commit_wen;
    logic [`REG_ADDR_WIDTH-1:0] commit_rd;
    logic [`XLEN-1:0]           commit_data;
    logic                       halt;
    logic                       illegal;

    logic [`INST_WIDTH-1:0] prog [PROG_LEN];
    logic                   valid_pat [2048];
    logic [10:0]            drive_cnt = '0;
    integer                 seed = 32'h6241_52c6;

    `include "rv_model.svh"

    rv_core i_rv_core (
        .clk(clk), .rst_n(rst_n), .inst(inst), .inst_valid(inst_valid),
        .fetch_pc(fetch_pc), .commit(commit), .commit_pc(commit_pc),
        .commit_wen(commit_wen), .commit_rd(commit_rd), .commit_data(commit_data),
        .halt(halt), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        inst       <= prog[fetch_pc[9:2]];  // answers the address sampled at this edge
        inst_valid <= valid_pat[drive_cnt];
        drive_cnt  <= drive_cnt + 11'd1;
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic abort(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_commit(input logic exp_commit, input logic [`XLEN-1:0] pc,
                                input logic [`REG_ADDR_WIDTH-1:0] rd, input logic wen,
                                input logic [`XLEN-1:0] data);
        if (commit !== exp_commit) begin
            abort($sformatf("FAIL %0t: commit is %b, expected %b", $time, commit, exp_commit));
        end
        if (exp_commit) begin
            if (commit_pc !== pc) begin
                abort($sformatf("FAIL %0t: commit_pc %h, expected %h", $time, commit_pc, pc));
            end
            if (commit_wen !== wen) begin
                abort($sformatf("FAIL %0t: pc %h commit_wen %b, expected %b",
                                $time, pc, commit_wen, wen));
            end
            if (wen && (commit_rd !== rd || commit_data !== data)) begin
                abort($sformatf("FAIL %0t: pc %h writes x%0d = %h, expected x%0d = %h",
                                $time, pc, commit_rd, commit_data, rd, data));
            end
        end
    endtask

    task automatic check_halt(input logic exp);
        if (halt !== exp) abort($sformatf("FAIL %0t: halt is %b, expected %b", $time, halt, exp));
    endtask

    task automatic check_illegal(input logic exp);
        if (illegal !== exp) begin
            abort($sformatf("FAIL %0t: illegal is %b, expected %b", $time, illegal, exp));
        end
    endtask

    task automatic check_fetch_pc(input logic [`XLEN-1:0] exp);
        if (fetch_pc !== exp) begin
            abort($sformatf("FAIL %0t: fetch_pc %h, expected %h", $time, fetch_pc, exp));
        end
    endtask

    task automatic gen_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        int          off;
        for (int i = 0; i < 8; i++) begin
            prog[i] = enc_s(12'(8 * i), 5'd0, 5'd0, 3'b011);  // zero the doublewords in use
        end
        for (int i = 8; i < PROG_LEN - 1; i++) begin
            rd    = 5'(pick(16));
            rs1   = 5'(pick(16));
            rs2   = 5'(pick(16));
            imm   = 12'(pick(4096));
            upper = 20'(pick(1 << 20));
            off   = 4 * (1 + pick(6));  // forward only so the program always ends
            if (i + off / 4 > PROG_LEN - 1) off = 4 * (PROG_LEN - 1 - i);
            case (pick(13))
                0:  prog[i] = enc_i({7'h00, rs2}, rs1, 3'b000, rd, OP);
                1:  prog[i] = enc_i({7'h20, rs2}, rs1, 3'b000, rd, OP);
                2:  prog[i] = enc_i(imm, rs1, 3'b000, rd, OP_IMM);
                3:  prog[i] = enc_i(imm, rs1, 3'b011, rd, OP_IMM);
                4:  prog[i] = enc_i({7'h00, rs2}, rs1, 3'b000, rd, OP_32);
                5:  prog[i] = {upper, rd, LUI};
                6:  prog[i] = {upper, rd, AUIPC};
                7:  prog[i] = enc_i(12'(4 * pick(16)), 5'd0, 3'b010, rd, LOAD);
                8:  prog[i] = enc_s(12'(8 * pick(8)), rs2, 5'd0, 3'b011);
                9:  prog[i] = enc_j(21'(off), rd);
                10: prog[i] = enc_i(12'(4 * i + off + pick(2)), 5'd0, 3'b000, rd, JALR);
                11: prog[i] = enc_b(13'(off), rs2, rs1, 3'b000);
                default: prog[i] = enc_b(13'(off), rs2, rs1, 3'b001);
            endcase
        end
        prog[PROG_LEN - 1] = `EBREAK_INST;
        for (int k = 0; k < 2048; k++) valid_pat[k] = (pick(10) != 0);
    endtask

    task automatic load_illegal_program();
        for (int i = 0; i < PROG_LEN; i++) prog[i] = `EBREAK_INST;
        prog[0] = enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM);
        prog[1] = enc_i({7'h00, 5'd2}, 5'd1, 3'b100, 5'd3, OP);  // xor is outside the subset
        prog[2] = enc_i(12'd7, 5'd1, 3'b000, 5'd2, OP_IMM);
    endtask

    // resets the core, then follows it against the model until it has halted
    task automatic run_program();
        logic                       exp_wen;
        logic                       exp_bad;
        logic [`REG_ADDR_WIDTH-1:0] exp_rd;
        logic [`XLEN-1:0]           exp_data;
        logic [`XLEN-1:0]           pc;
        int                         cycles;
        int                         tail;
        cycles = 0;
        tail   = 0;
        reset_model();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_fetch_pc(`RESET_PC);
        check_commit(1'b0, '0, '0, 1'b0, '0);
        check_illegal(1'b0);
        check_halt(1'b0);
        while (tail < 4) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort($sformatf("timeout: the core did not halt within %0d cycles", TIMEOUT));
            end
            if (arch_halted) begin
                check_halt(1'b1);
                check_illegal(1'b0);
                check_commit(1'b0, '0, '0, 1'b0, '0);
                tail++;
            end else if (!inst_valid) begin
                check_halt(1'b0);
                check_illegal(1'b0);
                check_commit(1'b0, '0, '0, 1'b0, '0);
            end else if (commit || illegal) begin
                pc = arch_pc;
                step_model(prog[pc[9:2]], exp_wen, exp_rd, exp_data, exp_bad);
                check_halt(1'b0);
                check_illegal(exp_bad);
                check_commit(!exp_bad, pc, exp_rd, exp_wen, exp_data);
            end else begin
                check_halt(1'b0);
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        gen_program();
        run_program();
        load_illegal_program();
        run_program();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== common/dec_if.sv ====
`include "rv_defs.svh"

interface dec_if import rv_isa_pkg::*, rv_exec_pkg::*; ();

    logic                       branch;
    logic                       jump;
    logic                       jalr;
    logic                       reg_wen;
    logic [`REG_ADDR_WIDTH-1:0] reg_waddr;
    logic [`REG_ADDR_WIDTH-1:0] reg1_raddr;
    logic [`REG_ADDR_WIDTH-1:0] reg2_raddr;
    imm_fmt_e                   imm_fmt;
    alu_op_e                    alu_op;
    alu_src_e                   alu_src;
    logic                       mem_wen;
    logic                       mem_ren;
    ext_mode_e                  ext_mode;
    logic                       illegal;
    logic                       ebreak;

    modport ctrl_mp (
        output branch, jump, jalr, reg_wen, reg_waddr, reg1_raddr, reg2_raddr,
        output imm_fmt, alu_op, alu_src, mem_wen, mem_ren, ext_mode, illegal, ebreak
    );

    modport dp_mp (
        input branch, jump, jalr, reg_wen, reg_waddr, reg1_raddr, reg2_raddr,
        input imm_fmt, alu_op, alu_src, mem_wen, mem_ren, ext_mode, illegal, ebreak
    );

endinterface

// ==== common/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN           64
`define INST_WIDTH     32
`define REG_ADDR_WIDTH 5

// data ram size in doublewords
`define DRAM_DEPTH     64

`define RESET_PC       64'h0000_0000_0000_0000
`define EBREAK_INST    32'h0010_0073

`endif

// ==== common/rv_exec_pkg.sv ====
package rv_exec_pkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLTU,
        ALU_SUBN  // beq compare
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_IMM_PC,
        SRC_FOUR_PC
    } alu_src_e;

    typedef enum logic [1:0] {
        EXT_NONE,
        EXT_LOAD_W,
        EXT_WORD
    } ext_mode_e;

endpackage

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        OP_32  = 7'b0111011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_ADDI    = 3'b000;
    localparam logic [2:0] F3_SLTIU   = 3'b011;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SD      = 3'b011;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_fmt_e;

endpackage

// ==== core/alu.sv ====
`include "rv_defs.svh"

module alu import rv_exec_pkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    input  alu_op_e          op,
    input  alu_src_e         src,
    input  ext_mode_e        ext,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] raw;

    always_comb begin
        case (src)
            SRC_IMM: begin
                op_a = a;
                op_b = imm;
            end
            SRC_IMM_PC: begin
                op_a = pc;
                op_b = imm;
            end
            SRC_FOUR_PC: begin
                op_a = pc;
                op_b = 64'd4;  // return address
            end
            default: begin
                op_a = a;
                op_b = b;
            end
        endcase
    end

    always_comb begin
        case (op)
            ALU_SUB, ALU_SUBN: raw = op_a - op_b;
            ALU_SLTU:          raw = {63'b0, op_a < op_b};
            default:           raw = op_a + op_b;
        endcase
    end

    assign zero   = (raw == '0);
    assign result = (ext == EXT_WORD) ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== core/ctrl.sv ====
`include "rv_defs.svh"

module ctrl import rv_isa_pkg::*, rv_exec_pkg::*; (
    input  logic [`INST_WIDTH-1:0] inst,
    dec_if.ctrl_mp                 dec
);

    opcode_e                    opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        dec.branch     = 1'b0;
        dec.jump       = 1'b0;
        dec.jalr       = 1'b0;
        dec.reg_wen    = 1'b0;
        dec.reg_waddr  = rd;
        dec.reg1_raddr = rs1;
        dec.reg2_raddr = rs2;
        dec.imm_fmt    = IMM_I;
        dec.alu_op     = ALU_ADD;
        dec.alu_src    = SRC_REG;
        dec.mem_wen    = 1'b0;
        dec.mem_ren    = 1'b0;
        dec.ext_mode   = EXT_NONE;
        dec.illegal    = 1'b0;
        dec.ebreak     = 1'b0;
        case (opcode)
            OP: begin
                if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) begin
                    dec.reg_wen = 1'b1;
                end else if (funct3 == F3_ADD_SUB && funct7 == F7_ALT) begin
                    dec.reg_wen = 1'b1;
                    dec.alu_op  = ALU_SUB;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            OP_IMM: begin
                dec.alu_src = SRC_IMM;
                if (funct3 == F3_ADDI) begin
                    dec.reg_wen = 1'b1;
                end else if (funct3 == F3_SLTIU) begin
                    dec.reg_wen = 1'b1;
                    dec.alu_op  = ALU_SLTU;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            OP_32: begin
                dec.ext_mode = EXT_WORD;  // addw only
                if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) dec.reg_wen = 1'b1;
                else dec.illegal = 1'b1;
            end
            LOAD: begin
                dec.alu_src  = SRC_IMM;  // rs1 + imm address
                dec.ext_mode = EXT_LOAD_W;
                if (funct3 == F3_LW) begin
                    dec.reg_wen = 1'b1;
                    dec.mem_ren = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            STORE: begin
                dec.imm_fmt = IMM_S;
                dec.alu_src = SRC_IMM;
                if (funct3 == F3_SD) dec.mem_wen = 1'b1;
                else dec.illegal = 1'b1;
            end
            BRANCH: begin
                dec.imm_fmt = IMM_B;
                if (funct3 == F3_BEQ) begin
                    dec.branch = 1'b1;
                    dec.alu_op = ALU_SUBN;
                end else if (funct3 == F3_BNE) begin
                    dec.branch = 1'b1;
                    dec.alu_op = ALU_SUB;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            JAL: begin
                dec.jump    = 1'b1;
                dec.reg_wen = 1'b1;
                dec.imm_fmt = IMM_J;
                dec.alu_src = SRC_FOUR_PC;  // link value
            end
            JALR: begin
                dec.alu_src = SRC_FOUR_PC;
                if (funct3 == F3_JALR) begin
                    dec.jump    = 1'b1;
                    dec.jalr    = 1'b1;
                    dec.reg_wen = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            LUI: begin
                dec.reg_wen    = 1'b1;
                dec.reg1_raddr = '0;  // x0 + imm
                dec.imm_fmt    = IMM_U;
                dec.alu_src    = SRC_IMM;
            end
            AUIPC: begin
                dec.reg_wen = 1'b1;
                dec.imm_fmt = IMM_U;
                dec.alu_src = SRC_IMM_PC;
            end
            SYSTEM: begin
                if (inst == `EBREAK_INST) dec.ebreak = 1'b1;
                else dec.illegal = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// ==== core/imm_gen.sv ====
`include "rv_defs.svh"

module imm_gen import rv_isa_pkg::*; (
    input  logic [`INST_WIDTH-1:0] inst,
    input  imm_fmt_e               imm_fmt,
    output logic [`XLEN-1:0]       imm
);

    always_comb begin
        case (imm_fmt)
            IMM_S: imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B: begin
                imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            IMM_U:   imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            default: imm = {{52{inst[31]}}, inst[31:20]};  // I format
        endcase
    end

endmodule

// ==== core/regfile.sv ====
`include "rv_defs.svh"

module regfile (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
    output logic [`XLEN-1:0]           rdata1,
    output logic [`XLEN-1:0]           rdata2,
    input  logic                       wen,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic [`XLEN-1:0]           wdata
);

    logic [`XLEN-1:0] regs [1 << `REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 holds zero from reset through every later write
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (raddr1 == '0) |-> (rdata1 == '0));

endmodule

// ==== core/rv_core.sv ====
`include "rv_defs.svh"

module rv_core import rv_exec_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`INST_WIDTH-1:0]     inst,
    input  logic                       inst_valid,
    output logic [`XLEN-1:0]           fetch_pc,
    output logic                       commit,
    output logic [`XLEN-1:0]           commit_pc,
    output logic                       commit_wen,
    output logic [`REG_ADDR_WIDTH-1:0] commit_rd,
    output logic [`XLEN-1:0]           commit_data,
    output logic                       halt,
    output logic                       illegal
);

    logic [`XLEN-1:0] exec_pc;
    logic             flush;
    logic             inflight;  // a core-requested word is arriving
    logic             live;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] alu_result;
    logic             alu_zero;
    logic [`XLEN-1:0] ram_rdata;
    logic [`XLEN-1:0] load_data;
    logic             taken;
    logic [`XLEN-1:0] target;

    dec_if dec ();

    ctrl i_ctrl (.inst(inst), .dec(dec));

    imm_gen i_imm_gen (.inst(inst), .imm_fmt(dec.imm_fmt), .imm(imm));

    regfile i_regfile (
        .clk(clk), .rst_n(rst_n),
        .raddr1(dec.reg1_raddr), .raddr2(dec.reg2_raddr),
        .rdata1(rs1_data), .rdata2(rs2_data),
        .wen(commit_wen), .waddr(dec.reg_waddr), .wdata(commit_data)
    );

    alu i_alu (
        .a(rs1_data), .b(rs2_data), .pc(exec_pc), .imm(imm),
        .op(dec.alu_op), .src(dec.alu_src), .ext(dec.ext_mode),
        .result(alu_result), .zero(alu_zero)
    );

    data_ram i_data_ram (
        .clk(clk), .addr(alu_result), .wen(commit && dec.mem_wen),
        .wmask({8{dec.mem_wen}}), .wdata(rs2_data), .rdata(ram_rdata)
    );

    assign live    = inflight && !flush && !halt && inst_valid;
    assign commit  = live && !dec.illegal;
    assign illegal = live && dec.illegal;

    // beq taken on zero, bne on nonzero
    assign taken  = dec.jump || (dec.branch && ((dec.alu_op == ALU_SUBN) ? alu_zero : !alu_zero));
    assign target = dec.jalr ? ((rs1_data + imm) & ~64'd1) : (exec_pc + imm);

    assign load_data   = (dec.ext_mode == EXT_LOAD_W) ? {{32{ram_rdata[31]}}, ram_rdata[31:0]}
                                                      : ram_rdata;
    assign commit_pc   = exec_pc;
    assign commit_wen  = commit && dec.reg_wen;
    assign commit_rd   = dec.reg_waddr;
    assign commit_data = dec.mem_ren ? load_data : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= `RESET_PC;
            exec_pc  <= `RESET_PC;
            flush    <= 1'b0;
            inflight <= 1'b0;
            halt     <= 1'b0;
        end else begin
            exec_pc  <= fetch_pc;  // the word sampled now arrives next cycle
            inflight <= 1'b1;
            if (halt) begin
                fetch_pc <= fetch_pc;
            end else if (!inflight || flush) begin
                fetch_pc <= fetch_pc + 64'd4;
                flush    <= 1'b0;
            end else if (!inst_valid) begin
                fetch_pc <= exec_pc;  // refetch, drop the word already requested
                flush    <= 1'b1;
            end else if (dec.illegal || dec.ebreak) begin
                halt <= 1'b1;
            end else if (taken) begin
                fetch_pc <= target;
                flush    <= 1'b1;
            end else begin
                fetch_pc <= fetch_pc + 64'd4;
            end
        end
    end

endmodule

// ==== logic/data_ram.sv ====
`include "rv_defs.svh"

module data_ram (
    input  logic             clk,
    input  logic [`XLEN-1:0] addr,
    input  logic             wen,
    input  logic [7:0]       wmask,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata
);

    logic [`XLEN-1:0] mem [`DRAM_DEPTH];
    logic [`XLEN-1:0] dword;

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < 8; b++) begin
                if (wmask[b]) mem[addr[8:3]][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign dword = mem[addr[8:3]];
    assign rdata = addr[2] ? {dword[31:0], dword[63:32]} : dword;  // chosen word in low half

    no_unaligned_write: assert property (@(posedge clk) wen |-> (addr[2:0] == 3'b000));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_rv_core -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+common
+incdir+bench
common/rv_isa_pkg.sv
common/rv_exec_pkg.sv
common/dec_if.sv
core/ctrl.sv
core/imm_gen.sv
core/alu.sv
core/regfile.sv
logic/data_ram.sv
core/rv_core.sv
bench/tb_rv_core.sv
